// ==== src.f ====
logic/img_pkg.sv
logic/img_capture.sv
logic/pixel_fifo.sv
logic/img_stats.sv
logic/img_pipeline.sv
tests/img_pipeline_assertions.sv
tests/img_checker.sv
tests/tb_img_pipeline.sv

// ==== Bender.yml ====
package:
  name: img_pipeline

sources:
  - logic/img_pkg.sv
  - logic/img_capture.sv
  - logic/pixel_fifo.sv
  - logic/img_stats.sv
  - logic/img_pipeline.sv
  - target: test
    files:
      - tests/img_pipeline_assertions.sv
      - tests/img_checker.sv
      - tests/tb_img_pipeline.sv

// ==== tests/tb_img_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_img_pipeline import img_pkg::*; ();

    typedef struct packed {
        logic [11:0] width;
        logic [11:0] height;
        logic [15:0] gap;
        logic [1:0]  pattern;
        logic [11:0] short_row;
        logic [31:0] exp_status;
    } frame_t;

    localparam int num_frames = 5;
    localparam int line_gap = 3;
    localparam int ack_limit = 16;
    localparam logic [1:0] pat_grid = 2'd0;
    localparam logic [1:0] pat_ramp = 2'd1;
    localparam logic [1:0] pat_random = 2'd2;

    logic                    img_dclk;
    logic                    rst_n;
    logic [pix_width-1:0]    img_d;
    logic                    img_fv;
    logic                    img_lv;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [wb_adr_width-1:0] wb_adr;
    logic [wb_dat_width-1:0] wb_dat_w;
    logic [wb_dat_width-1:0] wb_dat_r;
    logic                    wb_ack;
    logic                    frame_done;

    frame_t frame_table [num_frames];
    integer seed;
    int     bus_errors = 0;
    int     cycle_count = 0;
    int     cycle_limit;
    int     total_errors;

    img_pipeline img_pipeline_i (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .img_d      (img_d),
        .img_fv     (img_fv),
        .img_lv     (img_lv),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .frame_done (frame_done)
    );

    img_checker checker_i (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .img_d      (img_d),
        .img_fv     (img_fv),
        .img_lv     (img_lv),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .frame_done (frame_done)
    );

    initial begin
        img_dclk = 1'b0;
        forever #4 img_dclk = ~img_dclk;
    end

    always @(posedge img_dclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Short row 0 means every line is full width
    task load_frame_table();
        frame_table[0] = '{width: 12'd16, height: 12'd12, gap: 16'd20, pattern: pat_grid,
                           short_row: 12'd0, exp_status: 32'h0};
        frame_table[1] = '{width: 12'd32, height: 12'd8, gap: 16'd12, pattern: pat_ramp,
                           short_row: 12'd0, exp_status: 32'h0};
        frame_table[2] = '{width: 12'd24, height: 12'd10, gap: 16'd16, pattern: pat_random,
                           short_row: 12'd4, exp_status: 32'h2};
        frame_table[3] = '{width: 12'd24, height: 12'd10, gap: 16'd16, pattern: pat_random,
                           short_row: 12'd0, exp_status: 32'h0};
        frame_table[4] = '{width: 12'd20, height: 12'd9, gap: 16'd8, pattern: pat_ramp,
                           short_row: 12'd7, exp_status: 32'h2};
    endtask

    function automatic logic [pix_width-1:0] pixel_value(input frame_t f, input int r,
                                                         input int c);
        logic [pix_width-1:0] value;
        case (f.pattern)
            pat_grid: value = (r % 4 == 0 || c % 4 == 0) ? 12'hfff : 12'h000;
            pat_ramp: value = pix_width'((c * 4096) / int'(f.width));
            default: value = pix_width'($random(seed));
        endcase
        return value;
    endfunction

    // Full frame minus the half line that a short row leaves out
    function automatic int frame_pixels(input frame_t f);
        int total;
        total = int'(f.width) * int'(f.height);
        if (f.short_row != 0) begin
            total -= int'(f.width) - int'(f.width) / 2;
        end
        return total;
    endfunction

    // Sensor model, one pixel per falling edge while the line is valid
    task drive_frame(input frame_t f);
        int line_w;
        img_fv = 1'b1;
        repeat (2) @(negedge img_dclk);
        for (int r = 0; r < int'(f.height); r++) begin
            line_w = (f.short_row != 0 && r == int'(f.short_row)) ? f.width / 2 : f.width;
            for (int c = 0; c < line_w; c++) begin
                img_lv = 1'b1;
                img_d = pixel_value(f, r, c);
                @(negedge img_dclk);
            end
            img_lv = 1'b0;
            img_d = '0;
            repeat (line_gap) @(negedge img_dclk);
        end
        img_fv = 1'b0;
        @(negedge img_dclk);
    endtask

    // Single Wishbone cycle, strobe can be held past the ack
    task bus_access(input logic we, input int adr, input logic [31:0] data, input int hold);
        int wait_cycles;
        wait_cycles = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = wb_adr_width'(adr);
        wb_dat_w = data;
        @(negedge img_dclk);
        while (!wb_ack && wait_cycles < ack_limit) begin
            wait_cycles++;
            @(negedge img_dclk);
        end
        if (!wb_ack) begin
            bus_errors++;
            $display("Wishbone ack never arrived for address %0d", adr);
        end
        repeat (hold + 1) @(negedge img_dclk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(negedge img_dclk);
    endtask

    task read_all_registers();
        for (int a = 0; a <= int'(reg_geometry); a++) begin
            bus_access(1'b0, a, 32'h0, 0);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        img_d = '0;
        img_fv = 1'b0;
        img_lv = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        seed = 32'h8fae8cf2;
        load_frame_table();
        // Frame time plus register traffic, with a wide margin
        cycle_limit = 100;
        for (int i = 0; i < num_frames; i++) begin
            cycle_limit += 2 * (3 + int'(frame_table[i].height)
                                * (int'(frame_table[i].width) + line_gap)
                                + int'(frame_table[i].gap) + 200);
        end
        repeat (3) @(negedge img_dclk);
        rst_n = 1'b1;
        @(negedge img_dclk);

        for (int i = 0; i < num_frames; i++) begin
            drive_frame(frame_table[i]);
            while (!frame_done) @(negedge img_dclk);
            // Bin registers are read only, this write must change nothing
            bus_access(1'b1, i % bin_count, 32'h00a5a5a5, 3);
            read_all_registers();
            checker_i.compare_frame(frame_table[i].width, frame_table[i].height,
                                    frame_pixels(frame_table[i]),
                                    frame_table[i].exp_status);
            bus_access(1'b1, int'(reg_status), 32'h3, 0);
            bus_access(1'b0, int'(reg_status), 32'h0, 0);
            checker_i.verify_status_cleared();
            repeat (frame_table[i].gap) @(negedge img_dclk);
        end

        total_errors = bus_errors + checker_i.error_count
                       + img_pipeline_i.assertions_i.fail_count;
        $display("Error counts: checker %0d, bus %0d, assertions %0d",
                 checker_i.error_count, bus_errors, img_pipeline_i.assertions_i.fail_count);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/img_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module img_checker import img_pkg::*; (
    input logic                    img_dclk,
    input logic                    rst_n,
    input logic [pix_width-1:0]    img_d,
    input logic                    img_fv,
    input logic                    img_lv,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_we,
    input logic [wb_adr_width-1:0] wb_adr,
    input logic [wb_dat_width-1:0] wb_dat_r,
    input logic                    wb_ack,
    input logic                    frame_done
);
    int                      hist [bin_count];
    int                      exp_bins [bin_count];
    int                      frames;
    int                      done_pulses;
    int                      strobes;
    int                      acks;
    int                      error_count = 0;
    logic                    fv_q;
    logic                    req;
    logic                    req_q;
    logic                    acked;
    logic [wb_dat_width-1:0] rd_val [32];

    // Everything is sampled on the rising edge, like the DUT sees it
    always @(posedge img_dclk) begin
        if (!rst_n) begin
            fv_q = 1'b0;
            req_q = 1'b0;
            acked = 1'b0;
            frames = 0;
            done_pulses = 0;
            strobes = 0;
            acks = 0;
            for (int i = 0; i < bin_count; i++) begin
                hist[i] = 0;
            end
        end else begin
            if (img_fv && img_lv) begin
                hist[img_d[pix_width-1 -: bin_sel_width]]++;
            end
            // Falling frame valid closes the expected histogram
            if (fv_q && !img_fv) begin
                frames++;
                for (int i = 0; i < bin_count; i++) begin
                    exp_bins[i] = hist[i];
                    hist[i] = 0;
                end
            end
            fv_q = img_fv;

            if (frame_done) begin
                done_pulses++;
            end

            req = wb_cyc && wb_stb;
            if (req && !req_q) begin
                strobes++;
            end
            if (wb_ack) begin
                if (!req) begin
                    error_count++;
                    $display("Wishbone ack seen with no strobe at address %0d", wb_adr);
                end else if (acked) begin
                    error_count++;
                    $display("Wishbone ack repeated within one strobe at address %0d", wb_adr);
                end else begin
                    acks++;
                    acked = 1'b1;
                    if (!wb_we) begin
                        rd_val[wb_adr] = wb_dat_r;
                    end
                end
            end
            if (!req) begin
                acked = 1'b0;
            end
            req_q = req;
        end
    end

    task check_value(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    // Register values read back after a frame against the bus model
    task compare_frame(input int width, input int height, input int pixel_total,
                       input logic [31:0] status);
        int sum;
        sum = 0;
        for (int i = 0; i < bin_count; i++) begin
            check_value($sformatf("bin[%0d]", i), rd_val[i], 32'(exp_bins[i]));
            sum += int'(rd_val[i]);
        end
        check_value("bin_sum", 32'(sum), 32'(pixel_total));
        check_value("frame_count", rd_val[reg_frame_count], 32'(frames));
        check_value("frame_done_count", 32'(done_pulses), 32'(frames));
        check_value("status", rd_val[reg_status], status);
        check_value("geometry", rd_val[reg_geometry],
                    32'((height << geometry_height_lsb) | width));
        check_value("wb_ack_count", 32'(acks), 32'(strobes));
        // Stale values must not pass the next frame
        for (int i = 0; i < 32; i++) begin
            rd_val[i] = 'x;
        end
    endtask

    task verify_status_cleared();
        check_value("status_after_clear", rd_val[reg_status], 32'h0);
        rd_val[reg_status] = 'x;
    endtask

endmodule

`default_nettype wire

// ==== tests/img_pipeline_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module img_pipeline_assertions (
    input logic img_dclk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic push,
    input logic full,
    input logic empty,
    input logic frame_done
);
    int   ack_repeat_fails = 0;
    int   ack_latency_fails = 0;
    int   push_empty_fails = 0;
    int   done_length_fails = 0;
    int   fail_count;
    logic ack_given;

    assign fail_count = ack_repeat_fails + ack_latency_fails + push_empty_fails
                        + done_length_fails;

    // Remembers an ack until the strobe drops
    always_ff @(posedge img_dclk) begin
        if (!rst_n || !(wb_cyc && wb_stb)) begin
            ack_given <= 1'b0;
        end else if (wb_ack) begin
            ack_given <= 1'b1;
        end
    end

    // At most one ack per strobe, however long it is held
    ack_once_per_strobe: assert property (@(posedge img_dclk) disable iff (!rst_n)
        wb_ack |-> !ack_given)
        else begin
            ack_repeat_fails++;
            $error("wb_ack given twice within one strobe");
        end

    // Ack follows a new strobe after one cycle
    ack_after_request: assert property (@(posedge img_dclk) disable iff (!rst_n)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else begin
            ack_latency_fails++;
            $error("wb_ack missing one cycle after cyc and stb rose");
        end

    // An accepted push leaves at least one entry behind
    push_fills_fifo: assert property (@(posedge img_dclk) disable iff (!rst_n)
        push && !full |=> !empty)
        else begin
            push_empty_fails++;
            $error("FIFO empty right after an accepted push");
        end

    done_one_cycle: assert property (@(posedge img_dclk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else begin
            done_length_fails++;
            $error("frame_done stayed high for more than one cycle");
        end

endmodule

bind img_pipeline img_pipeline_assertions assertions_i (
    .img_dclk   (img_dclk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .push       (push),
    .full       (full),
    .empty      (empty),
    .frame_done (frame_done)
);

`default_nettype wire

// ==== logic/img_pipeline.sv ====
`default_nettype none
`timescale 1ns/1ps

module img_pipeline import img_pkg::*; (
    input  logic                    img_dclk,
    input  logic                    rst_n,
    input  logic [pix_width-1:0]    img_d,
    input  logic                    img_fv,
    input  logic                    img_lv,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [wb_adr_width-1:0] wb_adr,
    input  logic [wb_dat_width-1:0] wb_dat_w,
    output logic [wb_dat_width-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic                    frame_done
);
    logic                 push;
    pixel_entry_t         push_entry;
    logic                 full;
    logic                 empty;
    logic                 pop;
    pixel_entry_t         pop_entry;
    logic [dim_width-1:0] frame_width;
    logic [dim_width-1:0] frame_height;
    logic                 frame_geometry_valid;
    logic                 short_line;
    logic                 overflow;

    // Producer on the sensor bus
    img_capture capture_i (
        .img_dclk             (img_dclk),
        .rst_n                (rst_n),
        .img_d                (img_d),
        .img_fv               (img_fv),
        .img_lv               (img_lv),
        .full                 (full),
        .push                 (push),
        .push_entry           (push_entry),
        .frame_width          (frame_width),
        .frame_height         (frame_height),
        .frame_geometry_valid (frame_geometry_valid),
        .short_line           (short_line),
        .overflow             (overflow)
    );

    pixel_fifo fifo_i (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .pop_entry  (pop_entry),
        .full       (full),
        .empty      (empty)
    );

    // Histogram and Wishbone readout
    img_stats stats_i (
        .img_dclk             (img_dclk),
        .rst_n                (rst_n),
        .empty                (empty),
        .pop_entry            (pop_entry),
        .frame_width          (frame_width),
        .frame_height         (frame_height),
        .frame_geometry_valid (frame_geometry_valid),
        .short_line           (short_line),
        .overflow             (overflow),
        .wb_cyc               (wb_cyc),
        .wb_stb               (wb_stb),
        .wb_we                (wb_we),
        .wb_adr               (wb_adr),
        .wb_dat_w             (wb_dat_w),
        .pop                  (pop),
        .wb_dat_r             (wb_dat_r),
        .wb_ack               (wb_ack),
        .frame_done           (frame_done)
    );

endmodule

`default_nettype wire

// ==== logic/img_stats.sv ====
`default_nettype none
`timescale 1ns/1ps

module img_stats import img_pkg::*; (
    input  logic                    img_dclk,
    input  logic                    rst_n,
    input  logic                    empty,
    input  pixel_entry_t            pop_entry,
    input  logic [dim_width-1:0]    frame_width,
    input  logic [dim_width-1:0]    frame_height,
    input  logic                    frame_geometry_valid,
    input  logic                    short_line,
    input  logic                    overflow,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [wb_adr_width-1:0] wb_adr,
    input  logic [wb_dat_width-1:0] wb_dat_w,
    output logic                    pop,
    output logic [wb_dat_width-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic                    frame_done
);
    logic [bin_width-1:0]     live_bins [bin_count];
    logic [bin_width-1:0]     bank_bins [bin_count];
    logic [bin_sel_width-1:0] bin_sel;
    logic [dim_width-1:0]     geo_width;
    logic [dim_width-1:0]     geo_height;
    logic [dim_width-1:0]     bank_width;
    logic [dim_width-1:0]     bank_height;
    logic [wb_dat_width-1:0]  frame_count;
    logic [status_width-1:0]  live_status;
    logic [status_width-1:0]  bank_status;
    logic [status_width-1:0]  status_set;
    logic [status_width-1:0]  status_clr;
    logic                     wb_req;
    logic                     wb_served;
    logic                     wb_take;
    logic [wb_dat_width-1:0]  rd_data;

    // Consumer never stalls
    assign pop = !empty;
    assign bin_sel = pop_entry.pixel[pix_width-1 -: bin_sel_width];
    assign frame_done = pop && pop_entry.eof;

    assign wb_req = wb_cyc && wb_stb;
    // One ack per strobe, even if the master holds it high
    assign wb_take = wb_req && !wb_ack && !wb_served;

    always_comb begin
        status_set = '0;
        status_set[status_overflow_bit] = overflow;
        status_set[status_short_line_bit] = short_line;
    end

    // Write-one-to-clear on the status word
    assign status_clr = (wb_take && wb_we && (wb_adr == reg_status)) ?
                        wb_dat_w[status_width-1:0] : '0;

    // Live histogram, cleared as the frame is banked
    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            for (int i = 0; i < bin_count; i++) begin
                live_bins[i] <= '0;
            end
        end else if (pop) begin
            for (int i = 0; i < bin_count; i++) begin
                if (pop_entry.eof) begin
                    live_bins[i] <= '0;
                end else if (bin_sel == bin_sel_width'(i)) begin
                    live_bins[i] <= live_bins[i] + 1'b1;
                end
            end
        end
    end

    // Bank includes the eof pixel itself
    always_ff @(posedge img_dclk) begin
        if (frame_done) begin
            for (int i = 0; i < bin_count; i++) begin
                bank_bins[i] <= live_bins[i] + bin_width'(bin_sel == bin_sel_width'(i));
            end
        end
    end

    always_ff @(posedge img_dclk) begin
        if (frame_geometry_valid) begin
            geo_width <= frame_width;
            geo_height <= frame_height;
        end
        if (frame_done) begin
            bank_width <= frame_geometry_valid ? frame_width : geo_width;
            bank_height <= frame_geometry_valid ? frame_height : geo_height;
        end
    end

    // Frame counter, sticky status and bus handshake
    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            frame_count <= '0;
            live_status <= '0;
            bank_status <= '0;
            wb_ack <= 1'b0;
            wb_served <= 1'b0;
        end else begin
            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
                bank_status <= (live_status | status_set) & ~status_clr;
            end else begin
                bank_status <= bank_status & ~status_clr;
            end
            live_status <= (live_status | status_set) & ~status_clr;
            wb_ack <= wb_take;
            wb_served <= wb_req && (wb_served || wb_ack);
        end
    end

    // Readout mux over banked values
    always_comb begin
        rd_data = '0;
        if (wb_adr < wb_adr_width'(bin_count)) begin
            rd_data = wb_dat_width'(bank_bins[wb_adr[bin_sel_width-1:0]]);
        end else begin
            case (wb_adr)
                reg_frame_count: rd_data = frame_count;
                reg_status: rd_data[status_width-1:0] = bank_status;
                reg_geometry: begin
                    rd_data[dim_width-1:0] = bank_width;
                    rd_data[geometry_height_lsb +: dim_width] = bank_height;
                end
                default: rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge img_dclk) begin
        if (wb_take) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pixel_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module pixel_fifo import img_pkg::*; (
    input  logic         img_dclk,
    input  logic         rst_n,
    input  logic         push,
    input  pixel_entry_t push_entry,
    input  logic         pop,
    output pixel_entry_t pop_entry,
    output logic         full,
    output logic         empty
);
    pixel_entry_t               mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign empty = (count == '0);

    // Full only blocks a push when no entry leaves in the same cycle
    assign full = (count == (fifo_addr_width + 1)'(fifo_depth)) && !pop;

    assign do_pop = pop && !empty;
    assign do_push = push && !full;

    // Head entry is visible without a read cycle
    assign pop_entry = mem[rd_ptr];

    always_ff @(posedge img_dclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/img_capture.sv ====
`default_nettype none
`timescale 1ns/1ps

module img_capture import img_pkg::*; (
    input  logic                 img_dclk,
    input  logic                 rst_n,
    input  logic [pix_width-1:0] img_d,
    input  logic                 img_fv,
    input  logic                 img_lv,
    input  logic                 full,
    output logic                 push,
    output pixel_entry_t         push_entry,
    output logic [dim_width-1:0] frame_width,
    output logic [dim_width-1:0] frame_height,
    output logic                 frame_geometry_valid,
    output logic                 short_line,
    output logic                 overflow
);
    logic [pix_width-1:0] d_r;
    logic                 fv_r;
    logic                 lv_r;
    logic                 fv_d;
    logic                 lv_d;
    logic [pix_width-1:0] hold_pixel;
    logic                 hold_valid;
    logic [dim_width-1:0] col_count;
    logic [dim_width-1:0] row_count;
    logic [dim_width-1:0] first_width;
    logic                 first_seen;
    logic                 pix_valid;
    logic                 line_end;
    logic                 frame_end;

    assign pix_valid = fv_r && lv_r;
    assign line_end = fv_d && lv_d && !lv_r;
    assign frame_end = fv_d && !fv_r;

    // A push the FIFO cannot take this cycle is lost
    assign overflow = push && full;

    // Sensor bus sampling plus one cycle of strobe history for edges
    always_ff @(posedge img_dclk) begin
        d_r <= img_d;
        if (!rst_n) begin
            fv_r <= 1'b0;
            lv_r <= 1'b0;
            fv_d <= 1'b0;
            lv_d <= 1'b0;
        end else begin
            fv_r <= img_fv;
            lv_r <= img_lv;
            fv_d <= fv_r;
            lv_d <= lv_r;
        end
    end

    // Each pixel waits in the hold register until its successor shows up,
    // so the line and frame tags are known when it is pushed
    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            push <= 1'b0;
        end else begin
            hold_valid <= pix_valid || (hold_valid && !frame_end);
            push <= hold_valid && (pix_valid || frame_end);
        end
    end

    always_ff @(posedge img_dclk) begin
        if (pix_valid) begin
            hold_pixel <= d_r;
        end
        if (hold_valid && (pix_valid || frame_end)) begin
            push_entry.pixel <= hold_pixel;
            // First pixel of a new line means the held one closed the previous
            push_entry.eol <= frame_end || !lv_d;
            push_entry.eof <= frame_end;
        end
    end

    // Column and row counting
    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            col_count <= '0;
            row_count <= '0;
            first_width <= '0;
            first_seen <= 1'b0;
            frame_geometry_valid <= 1'b0;
            short_line <= 1'b0;
        end else begin
            frame_geometry_valid <= frame_end;
            short_line <= line_end && first_seen && (col_count < first_width);
            if (pix_valid) begin
                col_count <= col_count + 1'b1;
            end else if (line_end) begin
                col_count <= '0;
            end
            if (frame_end) begin
                row_count <= '0;
                first_seen <= 1'b0;
            end else if (line_end) begin
                row_count <= row_count + 1'b1;
                if (!first_seen) begin
                    first_width <= col_count;
                    first_seen <= 1'b1;
                end
            end
        end
    end

    // Geometry snapshot; the last line may close on the same edge as the frame
    always_ff @(posedge img_dclk) begin
        if (frame_end) begin
            frame_width <= first_seen ? first_width : col_count;
            frame_height <= row_count + dim_width'(line_end);
        end
    end

endmodule

`default_nettype wire

// ==== logic/img_pkg.sv ====
`default_nettype none

package img_pkg;

    // Sensor pixel bus
    localparam int pix_width = 12;

    // Column and row counters, frames up to 4095 x 4095
    localparam int dim_width = 12;

    // Histogram from the top pixel bits
    localparam int bin_count = 16;
    localparam int bin_width = 24;
    localparam int bin_sel_width = $clog2(bin_count);

    // Pixel buffer between capture and statistics
    localparam int fifo_depth = 16;
    localparam int fifo_addr_width = 4;

    // Wishbone slave
    localparam int wb_adr_width = 5;
    localparam int wb_dat_width = 32;

    // Entry pushed by the capture block
    typedef struct packed {
        logic [pix_width-1:0] pixel;
        logic                 eol;
        logic                 eof;
    } pixel_entry_t;

    // Register map, word addresses 0 to 15 are the bins
    localparam logic [wb_adr_width-1:0] reg_frame_count = 5'd16;
    localparam logic [wb_adr_width-1:0] reg_status = 5'd17;
    localparam logic [wb_adr_width-1:0] reg_geometry = 5'd18;

    // Height sits in the upper half of the geometry word
    localparam int geometry_height_lsb = 16;

    // Sticky status bits
    localparam int status_width = 2;
    localparam int status_overflow_bit = 0;
    localparam int status_short_line_bit = 1;

endpackage

`default_nettype wire
